//--- filelist.f
design/apu_pkg.sv
design/apu_framecounter.sv
design/apu_pulse.sv
design/apu_noise.sv
design/apu_mixer.sv
design/apu.sv
bench/apu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the APU testbench with Verilator and run it
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module apu_tb -f filelist.f -o apu_sim \
    && ./obj_dir/apu_sim 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation passed"
exit 0

//--- bench/apu_tb.sv
`default_nettype none

module apu_tb;

    localparam int AUDIO_DEPTH = 16;
    localparam int MIX_BITS    = 7;     // weighted sum tops out at 120
    localparam int READ_LIMIT  = 4;
    localparam int FRAME_CLKS  = 4 * apu_pkg::QUARTER_CYCLES * 2;
    localparam int AUDIO_CLKS  = 4000;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_QUARTERS, OP_IRQ, OP_AUDIO, OP_IDLE} op_e;

    typedef struct {
        int          test;
        op_e         op;
        logic [15:0] addr;
        logic [7:0]  data;   // write data, read mask, quarter count, idle clocks or volume
        logic [7:0]  exp;
        logic [1:0]  pads;
    } step_t;

    logic                   clk;
    logic                   rst;
    logic [15:0]            addr;
    logic [7:0]             wdata;
    logic                   wr;
    logic                   rd;
    logic [1:0]             pads;
    logic [7:0]             rd_data;
    logic                   rd_valid;
    logic                   irq;
    logic [2:0]             strobe;
    logic [1:0]             ctrl_read;
    logic [AUDIO_DEPTH-1:0] audio;
    logic                   audio_en;

    step_t steps[$];
    int    errors;
    int    test_errs;
    int    tests_run;
    int    failed_tests;
    int    cur;
    string names[7] = '{"", "reset state and audio enable", "length counters and active bits",
                        "length expiry", "frame irq", "controller ports", "audio bound"};

    apu #(.AUDIO_DEPTH(AUDIO_DEPTH)) apu_i (
        .clk           (clk),
        .rst           (rst),
        .addr_i        (addr),
        .data_i        (wdata),
        .wr_i          (wr),
        .rd_i          (rd),
        .ctrl_data_i   (pads),
        .rd_data_o     (rd_data),
        .rd_valid_o    (rd_valid),
        .irq_o         (irq),
        .ctrl_strobe_o (strobe),
        .ctrl_read_o   (ctrl_read),
        .audio_o       (audio),
        .audio_en_o    (audio_en)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_step(input int t, input op_e op, input logic [15:0] a,
                            input logic [7:0] d, input logic [7:0] e, input logic [1:0] p);
        steps.push_back('{t, op, a, d, e, p});
    endtask

    task automatic note_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
        test_errs++;
    endtask

    task automatic note_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
        test_errs++;
    endtask

    // every task starts and ends 1 unit after a rising edge
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        @(posedge clk);
        #1;
        wr = 1'b0;
        if (a == 16'h4015 && audio_en !== (d[3] | d[1] | d[0])) begin
            note_mismatch("audio_en_o", audio_en, d[3] | d[1] | d[0]);
        end
        if (a == 16'h4016 && strobe !== d[2:0]) begin
            note_mismatch("ctrl_strobe_o", strobe, d[2:0]);
        end
    endtask

    task automatic bus_read(input logic [15:0] a, input logic [7:0] mask, input logic [7:0] exp);
        int         waited;
        logic [1:0] exp_pulse;
        exp_pulse = {a == 16'h4017, a == 16'h4016};
        addr   = a;
        rd     = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            rd = 1'b0;
            waited++;
        end while (rd_valid !== 1'b1 && waited < READ_LIMIT);
        if (rd_valid !== 1'b1) begin
            note_failure($sformatf("no rd_valid_o after a read of 0x%0h", a));
        end else begin
            if (waited != 1) begin
                note_failure($sformatf("read data came %0d cycles after rd_i", waited));
            end
            if ((rd_data & mask) !== exp) begin
                note_mismatch("rd_data_o", rd_data & mask, exp);
            end
            if (ctrl_read !== exp_pulse) begin
                note_mismatch("ctrl_read_o", ctrl_read, exp_pulse);
            end
        end
    endtask

    task automatic idle_clocks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_quarters(input int n);
        repeat (n * apu_pkg::QUARTER_CYCLES * 2 + 64) @(posedge clk);
        #1;
    endtask

    task automatic wait_irq(input logic expect_irq);
        int cycles;
        cycles = 0;
        while (irq !== 1'b1 && cycles < FRAME_CLKS + 256) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (expect_irq && irq !== 1'b1) begin
            note_failure("timeout waiting for irq_o");
        end
        if (!expect_irq && irq === 1'b1) begin
            note_failure("irq_o rose although the frame irq is inhibited");
        end
    endtask

    task automatic check_audio(input int vol);
        logic [AUDIO_DEPTH-1:0] loud;
        int                     bad;
        bit                     seen_zero;
        bit                     seen_loud;
        loud      = AUDIO_DEPTH'(3 * vol) << (AUDIO_DEPTH - MIX_BITS);  // pulse weight 3
        bad       = 0;
        seen_zero = 1'b0;
        seen_loud = 1'b0;
        for (int i = 0; i < AUDIO_CLKS; i++) begin
            @(posedge clk);
            #1;
            if (audio == '0) begin
                seen_zero = 1'b1;
            end else if (audio == loud) begin
                seen_loud = 1'b1;
            end else begin
                if (bad == 0) begin
                    note_mismatch("audio_o", audio, loud);
                end
                bad++;
            end
        end
        if (bad > 1) begin
            note_failure($sformatf("%0d more audio_o samples off both levels", bad - 1));
        end
        if (!seen_zero || !seen_loud) begin
            note_failure("audio_o did not swing between zero and the pulse level");
        end
    endtask

    task automatic build_table();
        logic [2:0] s;
        logic [1:0] p;
        int         vol;
        void'($urandom(32'hbcb39c05));
        s   = 3'($urandom);
        p   = 2'($urandom);
        vol = 1 + int'($urandom % 15);
        add_step(1, OP_READ, 16'h4015, 8'hff, 8'h00, 2'b00);
        add_step(1, OP_WRITE, 16'h4015, 8'h0b, 8'h00, 2'b00);
        add_step(2, OP_WRITE, 16'h4003, 8'h08, 8'h00, 2'b00);   // length index 1
        add_step(2, OP_WRITE, 16'h4007, 8'h08, 8'h00, 2'b00);
        add_step(2, OP_WRITE, 16'h400f, 8'h08, 8'h00, 2'b00);
        add_step(2, OP_READ, 16'h4015, 8'hff, 8'h0b, 2'b00);
        add_step(2, OP_WRITE, 16'h4015, 8'h00, 8'h00, 2'b00);
        add_step(2, OP_IDLE, 16'h0000, 8'd1, 8'h00, 2'b00);     // length drops one edge later
        add_step(2, OP_READ, 16'h4015, 8'hff, 8'h00, 2'b00);
        add_step(3, OP_WRITE, 16'h4015, 8'h01, 8'h00, 2'b00);
        add_step(3, OP_WRITE, 16'h4017, 8'h00, 8'h00, 2'b00);   // restart 4-step sequence
        add_step(3, OP_WRITE, 16'h4000, 8'h10, 8'h00, 2'b00);   // halt clear
        add_step(3, OP_WRITE, 16'h4003, 8'h18, 8'h00, 2'b00);   // length 2
        add_step(3, OP_READ, 16'h4015, 8'h01, 8'h01, 2'b00);
        add_step(3, OP_QUARTERS, 16'h0000, 8'd4, 8'h00, 2'b00);
        add_step(3, OP_READ, 16'h4015, 8'h01, 8'h00, 2'b00);
        add_step(4, OP_WRITE, 16'h4017, 8'h40, 8'h00, 2'b00);
        add_step(4, OP_WRITE, 16'h4017, 8'h00, 8'h00, 2'b00);
        add_step(4, OP_READ, 16'h4015, 8'h40, 8'h00, 2'b00);
        add_step(4, OP_IRQ, 16'h0000, 8'h00, 8'h01, 2'b00);
        add_step(4, OP_READ, 16'h4015, 8'h40, 8'h40, 2'b00);
        add_step(4, OP_READ, 16'h4015, 8'h40, 8'h00, 2'b00);
        add_step(4, OP_WRITE, 16'h4017, 8'h40, 8'h00, 2'b00);   // inhibit
        add_step(4, OP_IRQ, 16'h0000, 8'h00, 8'h00, 2'b00);
        add_step(4, OP_READ, 16'h4015, 8'h40, 8'h00, 2'b00);
        add_step(5, OP_WRITE, 16'h4016, {5'b0, s}, 8'h00, 2'b00);
        add_step(5, OP_READ, 16'h4016, 8'hff, {7'b0100000, p[0]}, p);
        add_step(5, OP_READ, 16'h4017, 8'hff, {7'b0100000, p[1]}, p);
        add_step(5, OP_READ, 16'h4016, 8'hff, {7'b0100000, ~p[0]}, ~p);
        add_step(5, OP_READ, 16'h4017, 8'hff, {7'b0100000, ~p[1]}, ~p);
        add_step(5, OP_WRITE, 16'h4016, {5'b0, ~s}, 8'h00, 2'b00);
        add_step(5, OP_WRITE, 16'h4016, 8'h00, 8'h00, 2'b00);
        add_step(6, OP_WRITE, 16'h4015, 8'h01, 8'h00, 2'b00);
        add_step(6, OP_WRITE, 16'h4000, 8'h90 | 8'(vol), 8'h00, 2'b00);  // 50% duty, const volume
        add_step(6, OP_WRITE, 16'h4001, 8'h00, 8'h00, 2'b00);
        add_step(6, OP_WRITE, 16'h4002, 8'h40, 8'h00, 2'b00);
        add_step(6, OP_WRITE, 16'h4003, 8'h08, 8'h00, 2'b00);
        add_step(6, OP_AUDIO, 16'h0000, 8'(vol), 8'h00, 2'b00);
    endtask

    task automatic apply_step(input step_t s);
        pads = s.pads;
        case (s.op)
            OP_WRITE:    bus_write(s.addr, s.data);
            OP_READ:     bus_read(s.addr, s.data, s.exp);
            OP_QUARTERS: wait_quarters(s.data);
            OP_IRQ:      wait_irq(s.exp[0]);
            OP_IDLE:     idle_clocks(s.data);
            default:     check_audio(s.data);
        endcase
    endtask

    task automatic report_test(input int t);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d, %s: passed", t, names[t]);
        end else begin
            failed_tests++;
            $display("test %0d, %s: failed with %0d errors", t, names[t], test_errs);
        end
    endtask

    initial begin
        rst          = 1'b1;
        addr         = '0;
        wdata        = '0;
        wr           = 1'b0;
        rd           = 1'b0;
        pads         = '0;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        failed_tests = 0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        cur = 1;
        if (irq !== 1'b0) begin
            note_mismatch("irq_o", irq, 0);
        end
        if (audio_en !== 1'b0) begin
            note_mismatch("audio_en_o", audio_en, 0);
        end
        if (audio !== '0) begin
            note_mismatch("audio_o", audio, 0);
        end
        if (rd_valid !== 1'b0) begin
            note_mismatch("rd_valid_o", rd_valid, 0);
        end
        foreach (steps[i]) begin
            if (steps[i].test != cur) begin
                report_test(cur);
                cur       = steps[i].test;
                test_errs = 0;
            end
            apply_step(steps[i]);
        end
        report_test(cur);
        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/apu.sv
`default_nettype none

module apu #(
    parameter int AUDIO_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [15:0]            addr_i,
    input  logic [7:0]             data_i,
    input  logic                   wr_i,
    input  logic                   rd_i,
    input  logic [1:0]             ctrl_data_i,
    output logic [7:0]             rd_data_o,
    output logic                   rd_valid_o,
    output logic                   irq_o,
    output logic [2:0]             ctrl_strobe_o,
    output logic [1:0]             ctrl_read_o,
    output logic [AUDIO_DEPTH-1:0] audio_o,
    output logic                   audio_en_o
);

    logic       win_hit;
    logic [4:0] reg_addr;
    logic [7:0] reg_wdata;
    logic       reg_wr;
    logic       rd_hit;
    logic       status_rd;
    logic       ctrl1_rd;
    logic       ctrl2_rd;
    logic [2:0] enable;    // noise, pulse1, pulse0
    logic [7:0] status;

    logic apu_cycle;
    logic qtr_frame;
    logic half_frame;
    logic frame_irq;
    logic pulse0_active;
    logic pulse1_active;
    logic noise_active;
    logic [apu_pkg::SAMPLE_W-1:0] pulse0_sample;
    logic [apu_pkg::SAMPLE_W-1:0] pulse1_sample;
    logic [apu_pkg::SAMPLE_W-1:0] noise_sample;

    assign win_hit   = (addr_i & apu_pkg::APU_MASK) == apu_pkg::APU_BASE;
    assign reg_addr  = addr_i[4:0];
    assign reg_wdata = data_i;
    assign reg_wr    = wr_i && win_hit;
    assign rd_hit    = rd_i && win_hit;
    assign status_rd = rd_hit && (reg_addr == apu_pkg::REG_STATUS);
    assign ctrl1_rd  = rd_hit && (reg_addr == apu_pkg::REG_CTRL1);
    assign ctrl2_rd  = rd_hit && (reg_addr == apu_pkg::REG_CTRL2);

    assign status = {1'b0, frame_irq, 2'b00, noise_active, 1'b0, pulse1_active, pulse0_active};

    assign irq_o      = frame_irq;
    assign audio_en_o = |enable;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_o     <= '0;
            rd_valid_o    <= 1'b0;
            enable        <= '0;
            ctrl_strobe_o <= '0;
            ctrl_read_o   <= '0;
        end else begin
            rd_valid_o <= rd_hit;
            rd_data_o  <= '0;  // write-only offsets read as zero
            if (status_rd) begin
                rd_data_o <= status;
            end
            if (ctrl1_rd) begin
                rd_data_o <= {7'b0100000, ctrl_data_i[0]};
            end
            if (ctrl2_rd) begin
                rd_data_o <= {7'b0100000, ctrl_data_i[1]};
            end

            if (reg_wr && reg_addr == apu_pkg::REG_STATUS) begin
                enable <= {reg_wdata[3], reg_wdata[1:0]};
            end
            if (reg_wr && reg_addr == apu_pkg::REG_CTRL1) begin
                ctrl_strobe_o <= reg_wdata[2:0];
            end
            ctrl_read_o <= {ctrl2_rd, ctrl1_rd};  // serial clock to each pad
        end
    end

    apu_framecounter u_framecounter (
        .clk          (clk),
        .rst          (rst),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_wr_i     (reg_wr),
        .status_rd_i  (status_rd),
        .apu_cycle_o  (apu_cycle),
        .qtr_frame_o  (qtr_frame),
        .half_frame_o (half_frame),
        .irq_o        (frame_irq)
    );

    apu_pulse #(.CHANNEL_ID(0)) u_pulse0 (
        .clk          (clk),
        .rst          (rst),
        .apu_cycle_i  (apu_cycle),
        .qtr_frame_i  (qtr_frame),
        .half_frame_i (half_frame),
        .en_i         (enable[0]),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_wr_i     (reg_wr),
        .active_o     (pulse0_active),
        .sample_o     (pulse0_sample)
    );

    apu_pulse #(.CHANNEL_ID(1)) u_pulse1 (
        .clk          (clk),
        .rst          (rst),
        .apu_cycle_i  (apu_cycle),
        .qtr_frame_i  (qtr_frame),
        .half_frame_i (half_frame),
        .en_i         (enable[1]),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_wr_i     (reg_wr),
        .active_o     (pulse1_active),
        .sample_o     (pulse1_sample)
    );

    apu_noise u_noise (
        .clk          (clk),
        .rst          (rst),
        .apu_cycle_i  (apu_cycle),
        .qtr_frame_i  (qtr_frame),
        .half_frame_i (half_frame),
        .en_i         (enable[2]),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_wr_i     (reg_wr),
        .active_o     (noise_active),
        .sample_o     (noise_sample)
    );

    apu_mixer #(.AUDIO_DEPTH(AUDIO_DEPTH)) u_mixer (
        .clk      (clk),
        .rst      (rst),
        .pulse0_i (pulse0_sample),
        .pulse1_i (pulse1_sample),
        .noise_i  (noise_sample),
        .mix_o    (audio_o)
    );

endmodule

`default_nettype wire

//--- design/apu_mixer.sv
`default_nettype none

module apu_mixer #(
    parameter int AUDIO_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [apu_pkg::SAMPLE_W-1:0] pulse0_i,
    input  logic [apu_pkg::SAMPLE_W-1:0] pulse1_i,
    input  logic [apu_pkg::SAMPLE_W-1:0] noise_i,
    output logic [AUDIO_DEPTH-1:0]       mix_o
);

    logic [apu_pkg::MIX_W-1:0] sum;

    // linear mix, pulses weigh 3 and noise 2
    assign sum = apu_pkg::PULSE_WEIGHT * pulse0_i
               + apu_pkg::PULSE_WEIGHT * pulse1_i
               + apu_pkg::NOISE_WEIGHT * noise_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            mix_o <= '0;
        end else begin
            mix_o <= {sum, {(AUDIO_DEPTH - apu_pkg::MIX_W){1'b0}}};  // msb aligned
        end
    end

endmodule

`default_nettype wire

//--- design/apu_noise.sv
`default_nettype none

module apu_noise (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         apu_cycle_i,
    input  logic                         qtr_frame_i,
    input  logic                         half_frame_i,
    input  logic                         en_i,
    input  logic [4:0]                   reg_addr_i,
    input  logic [7:0]                   reg_wdata_i,
    input  logic                         reg_wr_i,
    output logic                         active_o,
    output logic [apu_pkg::SAMPLE_W-1:0] sample_o
);

    logic        wr0, wr2, wr3;
    logic        halt;
    logic        const_vol;
    logic [3:0]  volume;
    logic        mode;        // short loop, tap from bit 6
    logic [3:0]  period_idx;
    logic [11:0] timer;
    logic [14:0] lfsr;
    logic        feedback;
    logic [7:0]  length;
    logic        env_start;
    logic [3:0]  env_div;
    logic [3:0]  env_decay;

    assign wr0 = reg_wr_i && (reg_addr_i == apu_pkg::NOISE_OFFSET);
    assign wr2 = reg_wr_i && (reg_addr_i == apu_pkg::NOISE_OFFSET + 5'd2);
    assign wr3 = reg_wr_i && (reg_addr_i == apu_pkg::NOISE_OFFSET + 5'd3);

    assign feedback = lfsr[0] ^ (mode ? lfsr[6] : lfsr[1]);

    assign active_o = (length != '0);
    assign sample_o = (active_o && !lfsr[0]) ? (const_vol ? volume : env_decay) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            halt       <= 1'b0;
            const_vol  <= 1'b0;
            volume     <= '0;
            mode       <= 1'b0;
            period_idx <= '0;
            timer      <= '0;
            lfsr       <= 15'd1;  // must never be all zero
            length     <= '0;
            env_start  <= 1'b0;
            env_div    <= '0;
            env_decay  <= '0;
        end else begin
            if (apu_cycle_i) begin
                if (timer == '0) begin
                    timer <= apu_pkg::NOISE_PERIOD_TABLE[period_idx];
                    lfsr  <= {feedback, lfsr[14:1]};
                end else begin
                    timer <= timer - 12'd1;
                end
            end

            if (qtr_frame_i) begin
                if (env_start) begin
                    env_start <= 1'b0;
                    env_decay <= 4'd15;
                    env_div   <= volume;
                end else if (env_div == '0) begin
                    env_div <= volume;
                    if (env_decay != '0) begin
                        env_decay <= env_decay - 4'd1;
                    end else if (halt) begin
                        env_decay <= 4'd15;
                    end
                end else begin
                    env_div <= env_div - 4'd1;
                end
            end

            if (half_frame_i && length != '0 && !halt) begin
                length <= length - 8'd1;
            end

            if (wr0) begin
                halt      <= reg_wdata_i[5];
                const_vol <= reg_wdata_i[4];
                volume    <= reg_wdata_i[3:0];
            end
            if (wr2) begin
                mode       <= reg_wdata_i[7];
                period_idx <= reg_wdata_i[3:0];
            end
            if (wr3) begin
                env_start <= 1'b1;
                if (en_i) begin
                    length <= apu_pkg::LENGTH_TABLE[reg_wdata_i[7:3]];
                end
            end

            if (!en_i) begin
                length <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/apu_pulse.sv
`default_nettype none

module apu_pulse #(
    parameter int CHANNEL_ID = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         apu_cycle_i,
    input  logic                         qtr_frame_i,
    input  logic                         half_frame_i,
    input  logic                         en_i,
    input  logic [4:0]                   reg_addr_i,
    input  logic [7:0]                   reg_wdata_i,
    input  logic                         reg_wr_i,
    output logic                         active_o,
    output logic [apu_pkg::SAMPLE_W-1:0] sample_o
);

    logic [4:0]     base;
    logic           wr0, wr1, wr2, wr3;

    apu_pkg::duty_e duty;
    logic           halt;       // length halt, doubles as envelope loop
    logic           const_vol;
    logic [3:0]     volume;
    logic           sweep_en;
    logic [2:0]     sweep_period;
    logic           sweep_neg;
    logic [2:0]     sweep_shift;
    logic [10:0]    period;

    logic [10:0]    timer;
    logic [2:0]     seq;
    logic [7:0]     pattern;
    logic [7:0]     length;
    logic           env_start;
    logic [3:0]     env_div;
    logic [3:0]     env_decay;
    logic           sweep_reload;
    logic [2:0]     sweep_div;
    logic [11:0]    change;
    logic [11:0]    target;
    logic           mute;

    assign base = (CHANNEL_ID == 0) ? apu_pkg::PULSE0_OFFSET : apu_pkg::PULSE1_OFFSET;
    assign wr0  = reg_wr_i && (reg_addr_i == base);
    assign wr1  = reg_wr_i && (reg_addr_i == base + 5'd1);
    assign wr2  = reg_wr_i && (reg_addr_i == base + 5'd2);
    assign wr3  = reg_wr_i && (reg_addr_i == base + 5'd3);

    always_comb begin
        case (duty)
            apu_pkg::DUTY_12: pattern = 8'b0000_0010;
            apu_pkg::DUTY_25: pattern = 8'b0000_0110;
            apu_pkg::DUTY_50: pattern = 8'b0001_1110;
            default:          pattern = 8'b1111_1001;
        endcase
    end

    // pulse 1 negates in ones' complement, pulse 2 in twos'
    assign change = {1'b0, period} >> sweep_shift;
    assign target = sweep_neg
        ? {1'b0, period} - change - ((CHANNEL_ID == 0) ? 12'd1 : 12'd0)
        : {1'b0, period} + change;
    assign mute   = (length == '0) || (period < 11'd8) || target[11];

    assign active_o = (length != '0);
    assign sample_o = (mute || !pattern[seq]) ? '0 : (const_vol ? volume : env_decay);

    always_ff @(posedge clk) begin
        if (rst) begin
            duty         <= apu_pkg::DUTY_12;
            halt         <= 1'b0;
            const_vol    <= 1'b0;
            volume       <= '0;
            sweep_en     <= 1'b0;
            sweep_period <= '0;
            sweep_neg    <= 1'b0;
            sweep_shift  <= '0;
            period       <= '0;
            timer        <= '0;
            seq          <= '0;
            length       <= '0;
            env_start    <= 1'b0;
            env_div      <= '0;
            env_decay    <= '0;
            sweep_reload <= 1'b0;
            sweep_div    <= '0;
        end else begin
            if (apu_cycle_i) begin
                if (timer == '0) begin
                    timer <= period;
                    seq   <= seq - 3'd1;
                end else begin
                    timer <= timer - 11'd1;
                end
            end

            if (qtr_frame_i) begin
                if (env_start) begin
                    env_start <= 1'b0;
                    env_decay <= 4'd15;
                    env_div   <= volume;
                end else if (env_div == '0) begin
                    env_div <= volume;
                    if (env_decay != '0) begin
                        env_decay <= env_decay - 4'd1;
                    end else if (halt) begin
                        env_decay <= 4'd15;
                    end
                end else begin
                    env_div <= env_div - 4'd1;
                end
            end

            if (half_frame_i) begin
                if (sweep_div == '0 && sweep_en && sweep_shift != '0 && !mute) begin
                    period <= target[10:0];
                end
                if (sweep_div == '0 || sweep_reload) begin
                    sweep_div    <= sweep_period;
                    sweep_reload <= 1'b0;
                end else begin
                    sweep_div <= sweep_div - 3'd1;
                end
                if (length != '0 && !halt) begin
                    length <= length - 8'd1;
                end
            end

            if (wr0) begin
                duty      <= apu_pkg::duty_e'(reg_wdata_i[7:6]);
                halt      <= reg_wdata_i[5];
                const_vol <= reg_wdata_i[4];
                volume    <= reg_wdata_i[3:0];
            end
            if (wr1) begin
                sweep_en     <= reg_wdata_i[7];
                sweep_period <= reg_wdata_i[6:4];
                sweep_neg    <= reg_wdata_i[3];
                sweep_shift  <= reg_wdata_i[2:0];
                sweep_reload <= 1'b1;
            end
            if (wr2) begin
                period[7:0] <= reg_wdata_i;
            end
            if (wr3) begin
                period[10:8] <= reg_wdata_i[2:0];
                seq          <= '0;
                env_start    <= 1'b1;
                if (en_i) begin
                    length <= apu_pkg::LENGTH_TABLE[reg_wdata_i[7:3]];
                end
            end

            if (!en_i) begin
                length <= '0;  // disabled channel loses its length
            end
        end
    end

    a_disable_clears: assert property (@(posedge clk) disable iff (rst)
        !en_i |=> !active_o);

endmodule

`default_nettype wire

//--- design/apu_framecounter.sv
`default_nettype none

module apu_framecounter (
    input  logic       clk,
    input  logic       rst,
    input  logic [4:0] reg_addr_i,
    input  logic [7:0] reg_wdata_i,
    input  logic       reg_wr_i,
    input  logic       status_rd_i,
    output logic       apu_cycle_o,
    output logic       qtr_frame_o,
    output logic       half_frame_o,
    output logic       irq_o
);

    logic                 div_q;
    logic [11:0]          cyc_cnt;
    logic [2:0]           step;      // quarter index within the frame
    logic [2:0]           last_step;
    apu_pkg::frame_mode_e mode;
    logic                 inhibit;
    logic                 step_end;
    logic                 frame_wr;

    assign apu_cycle_o = div_q;
    assign frame_wr    = reg_wr_i && (reg_addr_i == apu_pkg::REG_FRAME);
    assign step_end    = div_q && (cyc_cnt == 12'(apu_pkg::QUARTER_CYCLES - 1));
    assign last_step   = (mode == apu_pkg::FRAME_5STEP) ? 3'd4 : 3'd3;

    // 5-step mode skips the quarter at step 3
    assign qtr_frame_o  = step_end && !(mode == apu_pkg::FRAME_5STEP && step == 3'd3);
    assign half_frame_o = step_end && (step == 3'd1 || step == last_step);

    always_ff @(posedge clk) begin
        if (rst) begin
            div_q   <= 1'b0;
            cyc_cnt <= '0;
            step    <= '0;
            mode    <= apu_pkg::FRAME_4STEP;
            inhibit <= 1'b0;
            irq_o   <= 1'b0;
        end else begin
            div_q <= ~div_q;

            if (step_end) begin
                cyc_cnt <= '0;
                step    <= (step == last_step) ? 3'd0 : step + 3'd1;
            end else if (div_q) begin
                cyc_cnt <= cyc_cnt + 12'd1;
            end

            if (status_rd_i) begin
                irq_o <= 1'b0;
            end
            if (step_end && mode == apu_pkg::FRAME_4STEP && step == 3'd3 && !inhibit) begin
                irq_o <= 1'b1;
            end

            if (frame_wr) begin
                mode    <= apu_pkg::frame_mode_e'(reg_wdata_i[7]);
                inhibit <= reg_wdata_i[6];
                cyc_cnt <= '0;  // restart the sequence
                step    <= '0;
                if (reg_wdata_i[6]) begin
                    irq_o <= 1'b0;
                end
            end
        end
    end

    // a half frame is always also a quarter frame on an apu cycle
    a_half_in_qtr: assert property (@(posedge clk) disable iff (rst)
        half_frame_o |-> (qtr_frame_o && apu_cycle_o));

    // irq only rises with the half frame that closes a frame
    a_irq_rise: assert property (@(posedge clk) disable iff (rst)
        (!irq_o ##1 irq_o) |-> $past(half_frame_o));

endmodule

`default_nettype wire

//--- design/apu_pkg.sv
`default_nettype none

package apu_pkg;

    // register window 0x4000-0x401f
    localparam logic [15:0] APU_BASE = 16'h4000;
    localparam logic [15:0] APU_MASK = 16'hffe0;

    localparam logic [4:0] REG_STATUS = 5'h15;
    localparam logic [4:0] REG_CTRL1  = 5'h16;
    localparam logic [4:0] REG_CTRL2  = 5'h17;  // read side of 0x17
    localparam logic [4:0] REG_FRAME  = 5'h17;  // write side of 0x17

    localparam logic [4:0] PULSE0_OFFSET = 5'h00;
    localparam logic [4:0] PULSE1_OFFSET = 5'h04;
    localparam logic [4:0] NOISE_OFFSET  = 5'h0c;

    localparam logic [7:0] LENGTH_TABLE [32] = '{
        8'd10, 8'd254, 8'd20, 8'd2,  8'd40, 8'd4,  8'd80, 8'd6,
        8'd160, 8'd8,  8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
        8'd12, 8'd16,  8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
        8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
    };

    // periods in apu cycles, half the cpu-cycle values
    localparam logic [11:0] NOISE_PERIOD_TABLE [16] = '{
        12'd2,   12'd4,   12'd8,   12'd16,  12'd32,  12'd48,  12'd64,   12'd80,
        12'd101, 12'd127, 12'd190, 12'd254, 12'd381, 12'd508, 12'd1017, 12'd2034
    };

    localparam int QUARTER_CYCLES = 3729;

    localparam int SAMPLE_W = 4;

    // mixer sum, max 3*15 + 3*15 + 2*15 = 120
    localparam int           MIX_W        = 7;
    localparam logic [6:0] PULSE_WEIGHT = 7'd3;
    localparam logic [6:0] NOISE_WEIGHT = 7'd2;

    typedef enum logic {
        FRAME_4STEP,
        FRAME_5STEP
    } frame_mode_e;

    typedef enum logic [1:0] {
        DUTY_12,
        DUTY_25,
        DUTY_50,
        DUTY_75
    } duty_e;

endpackage

`default_nettype wire
